// ==== Bender.yml ====
package:
  name: conv_transconv

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/weight_bank.sv
      - source/ifmap_bank.sv
      - source/pe_array.sv
      - source/output_accum_bram.sv
      - source/conv_transconv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_conv_transconv_top.sv

// ==== filelist.f ====
+incdir+source
source/conv_pkg.sv
source/weight_bank.sv
source/ifmap_bank.sv
source/pe_array.sv
source/output_accum_bram.sv
source/conv_transconv_top.sv
verif/tb_conv_transconv_top.sv

// ==== source/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Lane count of the engine
`define CONV_LANES 4

// Operand and accumulator widths
`define CONV_DW    16
`define CONV_ACC_W 32

// Address widths of the three memories
`define CONV_W_AW  6
`define CONV_I_AW  6
`define CONV_O_AW  6

// Depths follow from the address widths
`define CONV_W_DEPTH (1 << `CONV_W_AW)
`define CONV_I_DEPTH (1 << `CONV_I_AW)
`define CONV_O_DEPTH (1 << `CONV_O_AW)

// Broadcast lane select
`define CONV_SEL_W 2

`endif

// ==== source/conv_pkg.sv ====
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

    // ==============================
    // Mode and opcode
    // ==============================
    typedef enum logic {
        MODE_CONV      = 1'b0,
        MODE_TRANSCONV = 1'b1
    } conv_mode_e;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_CLEAR = 2'd1,
        OP_MAC   = 2'd2,
        OP_EJECT = 2'd3
    } pe_op_e;

    // ==============================
    // Scalars and lane vectors
    // ==============================
    // Named signed scalars keep lane selects signed
    typedef logic signed [`CONV_DW-1:0]    operand_t;
    typedef logic signed [`CONV_ACC_W-1:0] word_t;
    typedef logic [`CONV_W_AW-1:0]         waddr_t;
    typedef logic [`CONV_I_AW-1:0]         iaddr_t;
    typedef logic [`CONV_O_AW-1:0]         oaddr_t;

    typedef operand_t [`CONV_LANES-1:0] operand_vec_t;
    typedef word_t    [`CONV_LANES-1:0] word_vec_t;
    typedef waddr_t   [`CONV_LANES-1:0] waddr_vec_t;
    typedef iaddr_t   [`CONV_LANES-1:0] iaddr_vec_t;
    typedef oaddr_t   [`CONV_LANES-1:0] oaddr_vec_t;

    // Transposed output map, one target row per lane
    typedef oaddr_t   [`CONV_LANES-1:0] omap_t;

    // ==============================
    // Command and result
    // ==============================
    typedef struct packed {
        pe_op_e op;
        oaddr_t out_addr;
        logic   bias_en;
    } pe_cmd_t;

    typedef struct packed {
        logic      conv_valid;
        logic      partial_valid;
        word_vec_t words;
        oaddr_t    out_addr;
        logic      bias_en;
    } pe_result_t;

endpackage

`default_nettype wire

// ==== source/conv_transconv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_transconv_top
    import conv_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire conv_mode_e             conv_mode,

    // ==============================
    // Weight memory
    // ==============================
    input  wire logic [`CONV_LANES-1:0] w_we,
    input  wire waddr_vec_t             w_waddr,
    input  wire operand_vec_t           w_wdata,
    input  wire logic                   w_re,
    input  wire waddr_vec_t             w_raddr,

    // ==============================
    // Ifmap memory
    // ==============================
    input  wire logic [`CONV_LANES-1:0] if_we,
    input  wire iaddr_vec_t             if_waddr,
    input  wire operand_vec_t           if_wdata,
    input  wire logic                   if_re,
    input  wire iaddr_vec_t             if_raddr,
    input  wire logic [`CONV_SEL_W-1:0] ifmap_sel,

    // ==============================
    // Command, bias and maps
    // ==============================
    input  wire pe_cmd_t                cmd,
    input  wire logic                   bias_we,
    input  wire oaddr_t                 bias_addr,
    input  wire word_vec_t              bias_data,
    input  wire logic [`CONV_LANES-1:0] cmap,
    input  wire omap_t                  omap,

    // ==============================
    // External read
    // ==============================
    input  wire logic                   rd_en,
    input  wire oaddr_vec_t             rd_addr,
    output logic                        rd_valid,
    output word_vec_t                   rd_data
);

    // Operands into the PE array
    operand_vec_t weight_data;
    operand_t     ifmap_data;

    // PE array into the output memory
    pe_result_t   result;

    weight_bank u_weight_bank (
        .clk         (clk),
        .reset       (reset),
        .w_we        (w_we),
        .w_waddr     (w_waddr),
        .w_wdata     (w_wdata),
        .w_re        (w_re),
        .w_raddr     (w_raddr),
        .weight_data (weight_data)
    );

    ifmap_bank u_ifmap_bank (
        .clk        (clk),
        .reset      (reset),
        .if_we      (if_we),
        .if_waddr   (if_waddr),
        .if_wdata   (if_wdata),
        .if_re      (if_re),
        .if_raddr   (if_raddr),
        .ifmap_sel  (ifmap_sel),
        .ifmap_data (ifmap_data)
    );

    // Same ifmap word reaches every lane
    pe_array u_pe_array (
        .clk         (clk),
        .reset       (reset),
        .conv_mode   (conv_mode),
        .cmd         (cmd),
        .weight_data (weight_data),
        .ifmap_data  (ifmap_data),
        .result      (result)
    );

    output_accum_bram u_output_accum_bram (
        .clk       (clk),
        .reset     (reset),
        .result    (result),
        .bias_we   (bias_we),
        .bias_addr (bias_addr),
        .bias_data (bias_data),
        .cmap      (cmap),
        .omap      (omap),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== source/ifmap_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module ifmap_bank
    import conv_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Masked write port
    input  wire logic [`CONV_LANES-1:0] if_we,
    input  wire iaddr_vec_t             if_waddr,
    input  wire operand_vec_t           if_wdata,

    // Read port
    input  wire logic                   if_re,
    input  wire iaddr_vec_t             if_raddr,
    input  wire logic [`CONV_SEL_W-1:0] ifmap_sel,

    // Single operand for the PE broadcast
    output operand_t                    ifmap_data
);

    // Raw word of every lane at its own read address
    operand_vec_t lane_rd;

    // ==============================
    // Lane memories
    // ==============================
    for (genvar g = 0; g < `CONV_LANES; g++) begin : g_lane
        operand_t mem [`CONV_I_DEPTH];

        always_ff @(posedge clk) begin
            if (if_we[g]) begin
                mem[if_waddr[g]] <= if_wdata[g];
            end
        end

        assign lane_rd[g] = mem[if_raddr[g]];
    end

    // ==============================
    // Lane select and output register
    // ==============================
    // Only the chosen lane is captured
    always_ff @(posedge clk) begin
        if (reset) begin
            ifmap_data <= '0;
        end else if (if_re) begin
            ifmap_data <= lane_rd[ifmap_sel];
        end
    end

endmodule

`default_nettype wire

// ==== source/output_accum_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module output_accum_bram
    import conv_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Results from the PE array
    input  wire pe_result_t             result,

    // Bias write port
    input  wire logic                   bias_we,
    input  wire oaddr_t                 bias_addr,
    input  wire word_vec_t              bias_data,

    // Transposed scatter maps
    input  wire logic [`CONV_LANES-1:0] cmap,
    input  wire omap_t                  omap,

    // External read port
    input  wire logic                   rd_en,
    input  wire oaddr_vec_t             rd_addr,
    output logic                        rd_valid,
    output word_vec_t                   rd_data
);

    // Next values for the two write modes
    word_vec_t conv_wdata;
    word_vec_t scatter_sum;

    // ==============================
    // Per-lane memories
    // ==============================
    for (genvar g = 0; g < `CONV_LANES; g++) begin : g_lane
        word_t out_mem  [`CONV_O_DEPTH];
        word_t bias_mem [`CONV_O_DEPTH];

        // Bias rows share one address across lanes
        always_ff @(posedge clk) begin
            if (bias_we) begin
                bias_mem[bias_addr] <= bias_data[g];
            end
        end

        // Conv write data
        // bias read at the tagged output row
        always_comb begin
            if (result.bias_en) begin
                conv_wdata[g] = result.words[g] + bias_mem[result.out_addr];
            end else begin
                conv_wdata[g] = result.words[g];
            end
        end

        // Read-modify-write through the output map
        // combinational read sees the previous cycle's write
        assign scatter_sum[g] = out_mem[omap[g]] + result.words[g];

        // Write port
        always_ff @(posedge clk) begin
            if (result.conv_valid) begin
                out_mem[result.out_addr] <= conv_wdata[g];
            end else if (result.partial_valid && cmap[g]) begin
                // Masked lanes keep their contents
                out_mem[omap[g]] <= scatter_sum[g];
            end
        end

        // External read data
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_data[g] <= out_mem[rd_addr[g]];
            end
        end
    end

    // ==============================
    // Read valid
    // ==============================
    // One cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// ==== source/pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module pe_array
    import conv_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire conv_mode_e   conv_mode,

    // Command issued alongside the memory reads
    input  wire pe_cmd_t      cmd,

    // Operands one cycle after the reads
    input  wire operand_vec_t weight_data,
    input  wire operand_t     ifmap_data,

    output pe_result_t        result
);

    // Command stage aligned with memory data
    pe_op_e     op_q;
    oaddr_t     tag_addr_q;
    logic       tag_bias_q;

    // Lane state
    word_vec_t  acc;
    word_vec_t  prod;

    // Decoded actions
    logic       do_mac;
    logic       do_partial;
    logic       do_eject;

    // Result register
    logic       conv_valid_q;
    logic       partial_valid_q;
    word_vec_t  words_q;
    oaddr_t     out_addr_q;
    logic       bias_en_q;

    // ==============================
    // Command delay
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            op_q <= OP_NOP;
        end else begin
            op_q <= cmd.op;
        end
    end

    // Tag travels with the opcode
    always_ff @(posedge clk) begin
        tag_addr_q <= cmd.out_addr;
        tag_bias_q <= cmd.bias_en;
    end

    // ==============================
    // Lane multipliers
    // ==============================
    // Broadcast ifmap times per-lane weight
    always_comb begin
        for (int i = 0; i < `CONV_LANES; i++) begin
            prod[i] = word_t'(ifmap_data) * word_t'(weight_data[i]);
        end
    end

    // MAC accumulates in conv mode and scatters in transposed mode
    assign do_mac     = (op_q == OP_MAC) && (conv_mode == MODE_CONV);
    assign do_partial = (op_q == OP_MAC) && (conv_mode == MODE_TRANSCONV);
    // Eject works in either mode so transposed runs can zero rows
    assign do_eject   = (op_q == OP_EJECT);

    // Accumulators
    // eject leaves them untouched
    always_ff @(posedge clk) begin
        if (reset || (op_q == OP_CLEAR)) begin
            acc <= '0;
        end else if (do_mac) begin
            for (int i = 0; i < `CONV_LANES; i++) begin
                acc[i] <= acc[i] + prod[i];
            end
        end
    end

    // ==============================
    // Result stage
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            conv_valid_q    <= 1'b0;
            partial_valid_q <= 1'b0;
        end else begin
            conv_valid_q    <= do_eject;
            partial_valid_q <= do_partial;
        end
    end

    // Sums on eject, raw products on a transposed MAC
    always_ff @(posedge clk) begin
        if (do_eject || do_partial) begin
            words_q    <= do_eject ? acc : prod;
            out_addr_q <= tag_addr_q;
            bias_en_q  <= tag_bias_q;
        end
    end

    assign result = '{
        conv_valid:    conv_valid_q,
        partial_valid: partial_valid_q,
        words:         words_q,
        out_addr:      out_addr_q,
        bias_en:       bias_en_q
    };

endmodule

`default_nettype wire

// ==== source/weight_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module weight_bank
    import conv_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Masked write port
    input  wire logic [`CONV_LANES-1:0] w_we,
    input  wire waddr_vec_t             w_waddr,
    input  wire operand_vec_t           w_wdata,

    // Read port
    input  wire logic                   w_re,
    input  wire waddr_vec_t             w_raddr,

    output operand_vec_t                weight_data
);

    // ==============================
    // One memory per lane
    // ==============================
    for (genvar g = 0; g < `CONV_LANES; g++) begin : g_lane
        operand_t mem [`CONV_W_DEPTH];

        // Lane owns its write enable
        always_ff @(posedge clk) begin
            if (w_we[g]) begin
                mem[w_waddr[g]] <= w_wdata[g];
            end
        end

        // Registered read
        // value holds until the next strobe
        always_ff @(posedge clk) begin
            if (reset) begin
                weight_data[g] <= '0;
            end else if (w_re) begin
                weight_data[g] <= mem[w_raddr[g]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_conv_transconv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module tb_conv_transconv_top
    import conv_pkg::*;
();

    localparam int CLK_PERIOD = 8;

    // Cycle budget of each test
    localparam int RESET_CYCLES   = 20;
    localparam int CONV_CYCLES    = 100;
    localparam int BIAS_CYCLES    = 30;
    localparam int TRANS_CYCLES   = 30;
    localparam int PIPE_CYCLES    = 30;
    localparam int MARGIN_CYCLES  = 100;
    localparam int BUDGET_CYCLES  = RESET_CYCLES + CONV_CYCLES + BIAS_CYCLES +
                                    TRANS_CYCLES + PIPE_CYCLES + MARGIN_CYCLES;

    // ==============================
    // DUT signals
    // ==============================
    logic                   clk;
    logic                   reset;
    conv_mode_e             conv_mode;
    logic [`CONV_LANES-1:0] w_we;
    waddr_vec_t             w_waddr;
    operand_vec_t           w_wdata;
    logic                   w_re;
    waddr_vec_t             w_raddr;
    logic [`CONV_LANES-1:0] if_we;
    iaddr_vec_t             if_waddr;
    operand_vec_t           if_wdata;
    logic                   if_re;
    iaddr_vec_t             if_raddr;
    logic [`CONV_SEL_W-1:0] ifmap_sel;
    pe_cmd_t                cmd;
    logic                   bias_we;
    oaddr_t                 bias_addr;
    word_vec_t              bias_data;
    logic [`CONV_LANES-1:0] cmap;
    omap_t                  omap;
    logic                   rd_en;
    oaddr_vec_t             rd_addr;
    logic                   rd_valid;
    word_vec_t              rd_data;

    // Reference model state
    operand_t w_mem [`CONV_LANES][`CONV_W_DEPTH];
    operand_t i_mem [`CONV_LANES][`CONV_I_DEPTH];
    word_t    o_mem [`CONV_LANES][`CONV_O_DEPTH];
    word_t    b_mem [`CONV_LANES][`CONV_O_DEPTH];
    word_t    acc_m [`CONV_LANES];

    logic [31:0] lcg_state = 32'h8074;
    int          errors = 0;
    int          checks = 0;

    conv_transconv_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Same row on every lane
    function automatic oaddr_vec_t row_vec(input oaddr_t a);
        oaddr_vec_t v;
        int         i;
        for (i = 0; i < `CONV_LANES; i++) begin
            v[i] = a;
        end
        return v;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_idle();
        w_we    = '0;
        w_re    = 1'b0;
        if_we   = '0;
        if_re   = 1'b0;
        bias_we = 1'b0;
        rd_en   = 1'b0;
        cmd     = '{op: OP_NOP, out_addr: '0, bias_en: 1'b0};
    endtask

    task automatic check_word_vec(input string name, input word_vec_t exp,
                                  input word_vec_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Full rows of random weights and ifmaps
    task automatic load_memories();
        int a;
        int i;
        for (a = 0; a < `CONV_W_DEPTH; a++) begin
            for (i = 0; i < `CONV_LANES; i++) begin
                w_waddr[i]  = waddr_t'(a);
                w_wdata[i]  = next_rand();
                w_mem[i][a] = w_wdata[i];
                if_waddr[i] = iaddr_t'(a);
                if_wdata[i] = next_rand();
                i_mem[i][a] = if_wdata[i];
            end
            w_we  = '1;
            if_we = '1;
            tick();
        end
        set_idle();
    endtask

    task automatic write_bias(input oaddr_t row);
        int i;
        bias_we   = 1'b1;
        bias_addr = row;
        for (i = 0; i < `CONV_LANES; i++) begin
            bias_data[i] = {next_rand(), next_rand()};
            b_mem[i][row] = bias_data[i];
        end
        tick();
        set_idle();
    endtask

    // One command per cycle
    // Model follows the rules as each command issues
    task automatic issue(input pe_op_e op, input oaddr_t row, input logic bias_on,
                         input waddr_vec_t wa, input iaddr_vec_t ia,
                         input logic [`CONV_SEL_W-1:0] sel);
        word_t p;
        int    i;
        cmd       = '{op: op, out_addr: row, bias_en: bias_on};
        w_re      = (op == OP_MAC);
        w_raddr   = wa;
        if_re     = (op == OP_MAC);
        if_raddr  = ia;
        ifmap_sel = sel;
        for (i = 0; i < `CONV_LANES; i++) begin
            case (op)
                OP_CLEAR: acc_m[i] = '0;
                OP_MAC: begin
                    p = word_t'(i_mem[sel][ia[sel]]) * word_t'(w_mem[i][wa[i]]);
                    if (conv_mode == MODE_CONV) begin
                        acc_m[i] = acc_m[i] + p;
                    end else if (cmap[i]) begin
                        o_mem[i][omap[i]] = o_mem[i][omap[i]] + p;
                    end
                end
                OP_EJECT: o_mem[i][row] = acc_m[i] + (bias_on ? b_mem[i][row] : '0);
                default: ;
            endcase
        end
        tick();
        set_idle();
    endtask

    task automatic issue_random_mac();
        waddr_vec_t             wa;
        iaddr_vec_t             ia;
        logic [`CONV_SEL_W-1:0] sel;
        logic [15:0]            r;
        int                     i;
        for (i = 0; i < `CONV_LANES; i++) begin
            wa[i] = waddr_t'(next_rand());
            ia[i] = iaddr_t'(next_rand());
        end
        r   = next_rand();
        sel = r[`CONV_SEL_W-1:0];
        issue(OP_MAC, '0, 1'b0, wa, ia, sel);
    endtask

    task automatic issue_ctrl(input pe_op_e op, input oaddr_t row, input logic bias_on);
        issue(op, row, bias_on, '0, '0, '0);
    endtask

    // Last result lands two cycles after its command
    task automatic flush();
        repeat (2) tick();
    endtask

    task automatic read_check(input oaddr_vec_t addr);
        word_vec_t exp;
        int        i;
        int        waited;
        for (i = 0; i < `CONV_LANES; i++) begin
            exp[i] = o_mem[i][addr[i]];
        end
        rd_en   = 1'b1;
        rd_addr = addr;
        tick();
        rd_en  = 1'b0;
        waited = 0;
        while (rd_valid !== 1'b1 && waited < 4) begin
            tick();
            waited++;
        end
        if (rd_valid !== 1'b1) begin
            $display("Read of rows %h never returned valid data", addr);
            errors++;
        end else begin
            check_word_vec("rd_data", exp, rd_data);
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset();
        check_bit("rd_valid", 1'b0, rd_valid);
        repeat (2) begin
            tick();
            check_bit("rd_valid", 1'b0, rd_valid);
        end
        rd_en   = 1'b1;
        rd_addr = row_vec(0);
        tick();
        rd_en = 1'b0;
        check_bit("rd_valid", 1'b1, rd_valid);
        tick();
        check_bit("rd_valid", 1'b0, rd_valid);
        // Accumulators start at zero
        issue_ctrl(OP_EJECT, 6'd1, 1'b0);
        flush();
        read_check(row_vec(1));
    endtask

    task automatic test_conv_dot();
        load_memories();
        issue_ctrl(OP_CLEAR, '0, 1'b0);
        repeat (6) issue_random_mac();
        issue_ctrl(OP_EJECT, 6'd5, 1'b0);
        flush();
        read_check(row_vec(5));
    endtask

    task automatic test_bias_persist();
        write_bias(6'd6);
        // Same sums again with bias on
        issue_ctrl(OP_EJECT, 6'd6, 1'b1);
        flush();
        read_check(row_vec(6));
        issue_ctrl(OP_CLEAR, '0, 1'b0);
        issue_random_mac();
        issue_ctrl(OP_EJECT, 6'd7, 1'b0);
        flush();
        read_check(row_vec(7));
    endtask

    task automatic test_transposed();
        // Zero the target rows
        issue_ctrl(OP_CLEAR, '0, 1'b0);
        issue_ctrl(OP_EJECT, 6'd20, 1'b0);
        issue_ctrl(OP_EJECT, 6'd21, 1'b0);
        issue_ctrl(OP_EJECT, 6'd22, 1'b0);
        flush();
        conv_mode = MODE_TRANSCONV;
        // Lane 2 masked
        // Its row still holds the dot product
        cmap = 4'b1011;
        omap = {6'd22, 6'd5, 6'd21, 6'd20};
        repeat (3) issue_random_mac();
        flush();
        read_check(oaddr_vec_t'(omap));
        conv_mode = MODE_CONV;
        cmap      = '0;
    endtask

    task automatic test_pipelined();
        issue_ctrl(OP_CLEAR, '0, 1'b0);
        issue_random_mac();
        issue_random_mac();
        issue_ctrl(OP_EJECT, 6'd30, 1'b0);
        issue_random_mac();
        issue_ctrl(OP_EJECT, 6'd31, 1'b0);
        issue_random_mac();
        issue_random_mac();
        issue_ctrl(OP_EJECT, 6'd32, 1'b0);
        flush();
        read_check(row_vec(30));
        read_check(row_vec(31));
        read_check(row_vec(32));
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        conv_mode = MODE_CONV;
        w_waddr   = '0;
        w_wdata   = '0;
        w_raddr   = '0;
        if_waddr  = '0;
        if_wdata  = '0;
        if_raddr  = '0;
        ifmap_sel = '0;
        bias_addr = '0;
        bias_data = '0;
        cmap      = '0;
        omap      = '0;
        rd_addr   = '0;
        set_idle();
        for (int i = 0; i < `CONV_LANES; i++) begin
            acc_m[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset();
        test_conv_dot();
        test_bias_persist();
        test_transposed();
        test_pipelined();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD);
        $display("Timeout: the run went past its cycle budget");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
